/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu.f */
+incdir+hdl
hdl/cpuPkg.sv
hdl/cpuIfs.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/vectorAlu.sv
hdl/executeStage.sv
hdl/cpu.sv
verification/cpu_sva.sv
verification/cpuTb.sv

/* hdl/cpu.sv */
// Four-stage vector CPU top level
`timescale 1ns/100ps

module cpu (
    input  logic           clk,
    input  logic           reset,
    input  cpuPkg::instr_t instrIn,
    output cpuPkg::addr_t  instrAddr,
    input  cpuPkg::word_t  dmemDataIn,
    output cpuPkg::word_t  dmemDataOut,
    output cpuPkg::addr_t  dmemAddr,
    output logic           dmemEn,
    output logic           dmemWrEn
);

    cpuPkg::instr_t   fetchedInstr;
    cpuPkg::addr_t    branchTarget;
    cpuPkg::regAddr_t rdAddr0;
    cpuPkg::regAddr_t rdAddr1;
    cpuPkg::word_t    rdData0;
    cpuPkg::word_t    rdData1;
    logic             branchTaken;

    // Execute result to decode, and write-back to the register file
    regWriteIf exFwd ();
    regWriteIf wbWrite ();
    idExIf     idEx ();

    fetchStage fetch_i (
        .clk          (clk),
        .reset        (reset),
        .instrIn      (instrIn),
        .instrAddr    (instrAddr),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .fetchedInstr (fetchedInstr)
    );

    decodeStage decode_i (
        .clk          (clk),
        .reset        (reset),
        .fetchedInstr (fetchedInstr),
        .rdAddr0      (rdAddr0),
        .rdAddr1      (rdAddr1),
        .rdData0      (rdData0),
        .rdData1      (rdData1),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .exFwd        (exFwd.sink),
        .idEx         (idEx.source),
        .dmemEn       (dmemEn),
        .dmemWrEn     (dmemWrEn),
        .dmemAddr     (dmemAddr),
        .dmemDataOut  (dmemDataOut)
    );

    regFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .wbWrite (wbWrite.sink),
        .rdAddr0 (rdAddr0),
        .rdAddr1 (rdAddr1),
        .rdData0 (rdData0),
        .rdData1 (rdData1)
    );

    executeStage execute_i (
        .clk        (clk),
        .reset      (reset),
        .idEx       (idEx.sink),
        .dmemDataIn (dmemDataIn),
        .exFwd      (exFwd.source),
        .wbWrite    (wbWrite.source)
    );

endmodule

/* hdl/cpuIfs.sv */
// Register write interface and decode/execute pipeline interface
`timescale 1ns/100ps

// One register write, used for forwarding and for write-back
interface regWriteIf;
    logic            wrEn;
    cpuPkg::regAddr_t wrAddr;
    cpuPkg::word_t    wrData;
    cpuPkg::ppp_t     ppp;

    modport source (output wrEn, output wrAddr, output wrData, output ppp);
    modport sink   (input wrEn, input wrAddr, input wrData, input ppp);
endinterface

// Contents of the decode/execute register
interface idExIf;
    cpuPkg::word_t     opA;
    cpuPkg::word_t     opB;
    cpuPkg::regAddr_t  rD;
    cpuPkg::ppp_t      ppp;
    cpuPkg::ww_t       ww;
    cpuPkg::funcCode_t funcCode;
    logic              memRead;
    logic              regWrite;

    modport source (output opA, output opB, output rD, output ppp, output ww,
                    output funcCode, output memRead, output regWrite);
    modport sink   (input opA, input opB, input rD, input ppp, input ww,
                    input funcCode, input memRead, input regWrite);
endinterface

/* hdl/cpuPkg.sv */
// Vector CPU typedefs and the partition-mode merge function
`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_W-1:0]  word_t;
    typedef logic [`CPU_INSTR_W-1:0] instr_t;
    typedef logic [`CPU_ADDR_W-1:0]  addr_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funcCode_t;
    typedef logic [2:0]  ppp_t;
    typedef logic [1:0]  ww_t;
    typedef logic [15:0] imm_t;

    // Replace the bytes of oldWord selected by ppp with those of newWord
    function automatic word_t mergeByPpp(word_t oldWord, word_t newWord, ppp_t ppp);
        logic [7:0] byteSel;
        word_t mask;
        // Leftmost select bit is byte 0
        case (ppp)
            `PPP_A:  byteSel = 8'b1111_1111;
            `PPP_U:  byteSel = 8'b1111_0000;
            `PPP_D:  byteSel = 8'b0000_1111;
            `PPP_E:  byteSel = 8'b1010_1010;
            `PPP_O:  byteSel = 8'b0101_0101;
            default: byteSel = 8'b0000_0000;
        endcase
        for (int k = 0; k < 8; k++) begin
            mask[8*k +: 8] = {8{byteSel[k]}};
        end
        return (oldWord & ~mask) | (newWord & mask);
    endfunction

endpackage

/* hdl/cpu_consts.svh */
// Widths, opcodes, ALU function codes and partition modes for the vector CPU
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Widths fixed by the instruction format
`define CPU_DATA_W      64
`define CPU_INSTR_W     32
`define CPU_ADDR_W      32
`define CPU_REG_COUNT   32

// Opcodes
`define OP_ALU          6'b101010
`define OP_BEZ          6'b100010
`define OP_BNEZ         6'b100011
`define OP_NOP          6'b111100
`define OP_LW           6'b100000
`define OP_SW           6'b100001

// ALU function codes
`define FN_VADD         6'b000110
`define FN_VSUB         6'b000111
`define FN_VSLL         6'b001010
`define FN_VSRL         6'b001011

// Partition modes, byte 0 is the most significant byte
`define PPP_A           3'b000
`define PPP_U           3'b001
`define PPP_D           3'b010
`define PPP_E           3'b011
`define PPP_O           3'b100

`endif

/* hdl/decodeStage.sv */
// Decode stage with control, forwarding, branch resolution and decode/execute register
`timescale 1ns/100ps
`include "cpu_consts.svh"

module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::instr_t   fetchedInstr,
    output cpuPkg::regAddr_t rdAddr0,
    output cpuPkg::regAddr_t rdAddr1,
    input  cpuPkg::word_t    rdData0,
    input  cpuPkg::word_t    rdData1,
    output logic             branchTaken,
    output cpuPkg::addr_t    branchTarget,
    regWriteIf.sink          exFwd,
    idExIf.source            idEx,
    output logic             dmemEn,
    output logic             dmemWrEn,
    output cpuPkg::addr_t    dmemAddr,
    output cpuPkg::word_t    dmemDataOut
);

    cpuPkg::opcode_t   opcode;
    cpuPkg::regAddr_t  rD;
    cpuPkg::regAddr_t  rA;
    cpuPkg::regAddr_t  rB;
    cpuPkg::ppp_t      ppp;
    cpuPkg::ww_t       ww;
    cpuPkg::funcCode_t funcCode;
    cpuPkg::imm_t      imm;
    cpuPkg::word_t     opA;
    cpuPkg::word_t     opB;
    logic isAlu, isLw, isSw, isBez, isBnez;
    logic fwdHit0, fwdHit1;

    // Field split
    assign opcode   = fetchedInstr[31:26];
    assign rD       = fetchedInstr[25:21];
    assign rA       = fetchedInstr[20:16];
    assign rB       = fetchedInstr[15:11];
    assign ww       = fetchedInstr[7:6];
    assign funcCode = fetchedInstr[5:0];
    assign imm      = fetchedInstr[15:0];

    assign isAlu  = (opcode == `OP_ALU);
    assign isLw   = (opcode == `OP_LW);
    assign isSw   = (opcode == `OP_SW);
    assign isBez  = (opcode == `OP_BEZ);
    assign isBnez = (opcode == `OP_BNEZ);

    // Loads always write the whole register
    assign ppp = isLw ? `PPP_A : fetchedInstr[10:8];

    // Stores and branches read rD on port 0
    assign rdAddr0 = (isSw || isBez || isBnez) ? rD : rA;
    assign rdAddr1 = rB;

    // Forward the in-flight execute result, merged by its partition mode
    assign fwdHit0 = exFwd.wrEn && (exFwd.wrAddr != '0) && (exFwd.wrAddr == rdAddr0);
    assign fwdHit1 = exFwd.wrEn && (exFwd.wrAddr != '0) && (exFwd.wrAddr == rdAddr1);
    assign opA = fwdHit0 ? cpuPkg::mergeByPpp(rdData0, exFwd.wrData, exFwd.ppp) : rdData0;
    assign opB = fwdHit1 ? cpuPkg::mergeByPpp(rdData1, exFwd.wrData, exFwd.ppp) : rdData1;

    assign branchTaken  = (isBez && (opA == '0)) || (isBnez && (opA != '0));
    assign branchTarget = cpuPkg::addr_t'(imm);

    // Memory request issued from decode, data returns during execute
    assign dmemEn      = isLw || isSw;
    assign dmemWrEn    = isSw;
    assign dmemAddr    = cpuPkg::addr_t'(imm);
    assign dmemDataOut = opA;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
        end else begin
            idEx.regWrite <= isAlu || isLw;
            idEx.memRead  <= isLw;
        end
    end

    always_ff @(posedge clk) begin
        idEx.opA      <= opA;
        idEx.opB      <= opB;
        idEx.rD       <= rD;
        idEx.ppp      <= ppp;
        idEx.ww       <= ww;
        idEx.funcCode <= funcCode;
    end

endmodule

/* hdl/executeStage.sv */
// Execute stage with ALU, result select, forwarding source and execute/write-back register
`timescale 1ns/100ps

module executeStage (
    input  logic          clk,
    input  logic          reset,
    idExIf.sink           idEx,
    input  cpuPkg::word_t dmemDataIn,
    regWriteIf.source     exFwd,
    regWriteIf.source     wbWrite
);

    cpuPkg::word_t aluResult;
    cpuPkg::word_t exResult;

    vectorAlu alu_i (
        .opA      (idEx.opA),
        .opB      (idEx.opB),
        .funcCode (idEx.funcCode),
        .ww       (idEx.ww),
        .result   (aluResult)
    );

    // Load data arrives from memory while the load is in execute
    assign exResult = idEx.memRead ? dmemDataIn : aluResult;

    assign exFwd.wrEn   = idEx.regWrite;
    assign exFwd.wrAddr = idEx.rD;
    assign exFwd.wrData = exResult;
    assign exFwd.ppp    = idEx.ppp;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbWrite.wrEn <= 1'b0;
        end else begin
            wbWrite.wrEn <= idEx.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbWrite.wrAddr <= idEx.rD;
        wbWrite.wrData <= exResult;
        wbWrite.ppp    <= idEx.ppp;
    end

endmodule

/* hdl/fetchStage.sv */
// Fetch stage with program counter and fetch/decode register
`timescale 1ns/100ps
`include "cpu_consts.svh"

module fetchStage (
    input  logic           clk,
    input  logic           reset,
    input  cpuPkg::instr_t instrIn,
    output cpuPkg::addr_t  instrAddr,
    input  logic           branchTaken,
    input  cpuPkg::addr_t  branchTarget,
    output cpuPkg::instr_t fetchedInstr
);

    localparam cpuPkg::instr_t NOP_INSTR = {`OP_NOP, 26'd0};

    cpuPkg::addr_t  pc;
    cpuPkg::instr_t ifId;

    assign instrAddr    = pc;
    assign fetchedInstr = ifId;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Taken branch squashes the instruction behind it
    always_ff @(posedge clk) begin
        if (reset || branchTaken) begin
            ifId <= NOP_INSTR;
        end else begin
            ifId <= instrIn;
        end
    end

endmodule

/* hdl/regFile.sv */
// 32x64 register file with partition-masked write and write-through reads
`timescale 1ns/100ps
`include "cpu_consts.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    regWriteIf.sink          wbWrite,
    input  cpuPkg::regAddr_t rdAddr0,
    input  cpuPkg::regAddr_t rdAddr1,
    output cpuPkg::word_t    rdData0,
    output cpuPkg::word_t    rdData1
);

    cpuPkg::word_t regs [`CPU_REG_COUNT];
    logic wbValid;

    // Register 0 is never written
    assign wbValid = wbWrite.wrEn && (wbWrite.wrAddr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbWrite.wrAddr] <= cpuPkg::mergeByPpp(regs[wbWrite.wrAddr],
                                                       wbWrite.wrData, wbWrite.ppp);
        end
    end

    // Pending write is visible in the same cycle
    always_comb begin
        rdData0 = regs[rdAddr0];
        if (wbValid && (wbWrite.wrAddr == rdAddr0)) begin
            rdData0 = cpuPkg::mergeByPpp(rdData0, wbWrite.wrData, wbWrite.ppp);
        end
    end

    always_comb begin
        rdData1 = regs[rdAddr1];
        if (wbValid && (wbWrite.wrAddr == rdAddr1)) begin
            rdData1 = cpuPkg::mergeByPpp(rdData1, wbWrite.wrData, wbWrite.ppp);
        end
    end

endmodule

/* hdl/vectorAlu.sv */
// Lane-wise vector add, subtract and logical shifts
`timescale 1ns/100ps
`include "cpu_consts.svh"

module vectorAlu (
    input  cpuPkg::word_t     opA,
    input  cpuPkg::word_t     opB,
    input  cpuPkg::funcCode_t funcCode,
    input  cpuPkg::ww_t       ww,
    output cpuPkg::word_t     result
);

    always_comb begin
        cpuPkg::word_t msbMask;
        int laneW;
        int lo;
        int amt;
        int src;
        laneW = 8 << ww;
        // Top bit of every lane
        case (ww)
            2'b00:   msbMask = 64'h8080_8080_8080_8080;
            2'b01:   msbMask = 64'h8000_8000_8000_8000;
            2'b10:   msbMask = 64'h8000_0000_8000_0000;
            default: msbMask = 64'h8000_0000_0000_0000;
        endcase
        result = '0;
        case (funcCode)
            // Lane MSBs handled apart so no carry or borrow crosses a lane
            `FN_VADD: result = ((opA & ~msbMask) + (opB & ~msbMask))
                               ^ ((opA ^ opB) & msbMask);
            `FN_VSUB: result = ((opA | msbMask) - (opB & ~msbMask))
                               ^ ((opA ^ opB ^ msbMask) & msbMask);
            `FN_VSLL, `FN_VSRL: begin
                for (int j = 0; j < `CPU_DATA_W; j++) begin
                    lo  = j & ~(laneW - 1);
                    amt = int'(opB[lo +: 6]) & (laneW - 1);
                    src = (funcCode == `FN_VSLL) ? j - amt : j + amt;
                    // Bits shifted in from outside the lane stay zero
                    if (src >= lo && src < lo + laneW) begin
                        result[j] = opA[src];
                    end
                end
            end
            default: result = '0;
        endcase
    end

endmodule

/* verification/cpuTb.sv */
// Testbench for the vector CPU with memory models, directed tests and checks
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuTb;

    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 3;
    localparam int MEM_WORDS    = 64;
    // Programs need about 150 cycles in total, so this leaves ample margin
    localparam int CYCLE_LIMIT  = 400;

    logic clk = 1'b0;
    logic reset;
    cpuPkg::instr_t instrIn;
    cpuPkg::addr_t  instrAddr;
    cpuPkg::word_t  dmemDataIn = '0;
    cpuPkg::word_t  dmemDataOut;
    cpuPkg::addr_t  dmemAddr;
    logic dmemEn;
    logic dmemWrEn;

    cpuPkg::instr_t imem [MEM_WORDS];
    cpuPkg::word_t  dmem [MEM_WORDS];
    cpuPkg::word_t  dmemInit [MEM_WORDS];
    cpuPkg::addr_t  fetchTrace [$];
    logic [31:0] lfsrState = 32'd96080;
    int pcIdx;
    int valueErrors = 0;
    int otherErrors = 0;
    int cycleCount = 0;

    cpu cpu_i (
        .clk         (clk),
        .reset       (reset),
        .instrIn     (instrIn),
        .instrAddr   (instrAddr),
        .dmemDataIn  (dmemDataIn),
        .dmemDataOut (dmemDataOut),
        .dmemAddr    (dmemAddr),
        .dmemEn      (dmemEn),
        .dmemWrEn    (dmemWrEn)
    );

    always #2 clk = ~clk;

    assign instrIn = imem[instrAddr[7:2]];

    // Data memory with one cycle read latency, reloaded while in reset
    always @(posedge clk) begin
        if (reset) begin
            dmem <= dmemInit;
            dmemDataIn <= '0;
        end else begin
            if (dmemEn) begin
                dmemDataIn <= dmem[dmemAddr[5:0]];
            end
            if (dmemWrEn) begin
                dmem[dmemAddr[5:0]] <= dmemDataOut;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: no halt reached within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] nextLfsr(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic cpuPkg::word_t randWord();
        cpuPkg::word_t w;
        for (int i = 0; i < 64; i++) begin
            lfsrState = nextLfsr(lfsrState);
            w[i] = lfsrState[0];
        end
        return w;
    endfunction

    function automatic cpuPkg::word_t fillWord(int i);
        return {32'hC0DE_0000 + 32'(i), ~32'(i)};
    endfunction

    function automatic cpuPkg::instr_t encAlu(int rd, int ra, int rb, cpuPkg::ppp_t p,
                                              cpuPkg::ww_t w, cpuPkg::funcCode_t fn);
        return {`OP_ALU, cpuPkg::regAddr_t'(rd), cpuPkg::regAddr_t'(ra),
                cpuPkg::regAddr_t'(rb), p, w, fn};
    endfunction

    function automatic cpuPkg::instr_t encImm(cpuPkg::opcode_t op, int rd, int imm);
        return {op, cpuPkg::regAddr_t'(rd), 5'd0, cpuPkg::imm_t'(imm)};
    endfunction

    // Lane rule, each lane handled on its own
    function automatic cpuPkg::word_t laneRef(cpuPkg::funcCode_t fn, cpuPkg::word_t a,
                                              cpuPkg::word_t b, cpuPkg::ww_t ww);
        cpuPkg::word_t r;
        cpuPkg::word_t mask;
        cpuPkg::word_t la;
        cpuPkg::word_t lb;
        cpuPkg::word_t lr;
        int w;
        int amt;
        w = 8 << ww;
        mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        r = '0;
        for (int n = 0; n < 64 / w; n++) begin
            la = (a >> (n * w)) & mask;
            lb = (b >> (n * w)) & mask;
            amt = int'(lb[5:0]) & (w - 1);
            case (fn)
                `FN_VADD: lr = la + lb;
                `FN_VSUB: lr = la - lb;
                `FN_VSLL: lr = la << amt;
                `FN_VSRL: lr = la >> amt;
                default:  lr = '0;
            endcase
            r = r | ((lr & mask) << (n * w));
        end
        return r;
    endfunction

    // Byte 0 is the most significant byte
    function automatic cpuPkg::word_t mergeRef(cpuPkg::word_t oldW, cpuPkg::word_t newW,
                                               cpuPkg::ppp_t p);
        cpuPkg::word_t r;
        logic take;
        r = oldW;
        for (int k = 0; k < 8; k++) begin
            case (p)
                `PPP_A:  take = 1'b1;
                `PPP_U:  take = (k < 4);
                `PPP_D:  take = (k >= 4);
                `PPP_E:  take = (k % 2 == 0);
                `PPP_O:  take = (k % 2 == 1);
                default: take = 1'b0;
            endcase
            if (take) begin
                r[63 - 8 * k -: 8] = newW[63 - 8 * k -: 8];
            end
        end
        return r;
    endfunction

    task automatic compareWord(string name, cpuPkg::word_t expected, cpuPkg::word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareAddr(string name, cpuPkg::addr_t expected, cpuPkg::addr_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("** Error [%s]: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic emit(cpuPkg::instr_t instr);
        imem[pcIdx] = instr;
        pcIdx++;
    endtask

    // Hold the DUT in reset and clear both memories
    task automatic beginTest();
        @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        pcIdx = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {`OP_NOP, 26'd0};
            dmemInit[i] = fillWord(i);
        end
    endtask

    task automatic releaseReset();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    // Append a branch-to-self and run until it has been taken once
    task automatic runToHalt();
        cpuPkg::addr_t haltAddr;
        int seen;
        haltAddr = cpuPkg::addr_t'(pcIdx * 4);
        emit(encImm(`OP_BEZ, 0, pcIdx * 4));
        releaseReset();
        fetchTrace.delete();
        seen = 0;
        while (seen < 2) begin
            @(negedge clk);
            fetchTrace.push_back(instrAddr);
            if (instrAddr == haltAddr) begin
                seen++;
            end
        end
    endtask

    task automatic checkFollows(string name, cpuPkg::addr_t from, cpuPkg::addr_t next);
        int idx;
        idx = -1;
        for (int i = 0; i + 1 < fetchTrace.size(); i++) begin
            if (idx < 0 && fetchTrace[i] == from) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            otherErrors++;
            $display("%s: no fetch seen after address %h", name, from);
        end else begin
            compareAddr(name, next, fetchTrace[idx + 1]);
        end
    endtask

    // Reset in the middle of a running store loop
    task automatic resetTest();
        beginTest();
        emit(encImm(`OP_SW, 0, 1));
        emit(encImm(`OP_BEZ, 0, 0));
        releaseReset();
        // Stop with the store in decode and the PC at 4
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        compareAddr("reset instrAddr", '0, instrAddr);
        compareBit("reset dmemEn", 1'b0, dmemEn);
        compareBit("reset dmemWrEn", 1'b0, dmemWrEn);
    endtask

    task automatic laneTest();
        cpuPkg::funcCode_t fns [4] = '{`FN_VADD, `FN_VSUB, `FN_VSLL, `FN_VSRL};
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        beginTest();
        a = randWord();
        b = randWord();
        dmemInit[0] = a;
        dmemInit[1] = b;
        emit(encImm(`OP_LW, 1, 0));
        emit(encImm(`OP_LW, 2, 1));
        for (int f = 0; f < 4; f++) begin
            for (int w = 0; w < 4; w++) begin
                emit(encAlu(3, 1, 2, `PPP_A, cpuPkg::ww_t'(w), fns[f]));
                emit(encImm(`OP_SW, 3, 16 + 4 * f + w));
            end
        end
        runToHalt();
        for (int f = 0; f < 4; f++) begin
            for (int w = 0; w < 4; w++) begin
                compareWord($sformatf("lanes fn%0d ww%0d", f, w),
                            laneRef(fns[f], a, b, cpuPkg::ww_t'(w)), dmem[16 + 4 * f + w]);
            end
        end
    endtask

    // Dependencies at distances one, two and three
    task automatic forwardTest();
        cpuPkg::word_t x;
        cpuPkg::word_t y;
        cpuPkg::word_t r3;
        cpuPkg::word_t r4;
        cpuPkg::word_t r5;
        cpuPkg::word_t r6;
        cpuPkg::word_t r7;
        beginTest();
        x = randWord();
        y = randWord();
        dmemInit[0] = x;
        dmemInit[1] = y;
        emit(encImm(`OP_LW, 1, 0));
        emit(encImm(`OP_LW, 2, 1));
        emit(encAlu(3, 1, 2, `PPP_A, 2'b11, `FN_VADD));
        emit(encAlu(4, 3, 1, `PPP_A, 2'b10, `FN_VSUB));
        emit(encAlu(5, 4, 3, `PPP_A, 2'b01, `FN_VADD));
        emit(encImm(`OP_SW, 5, 20));
        emit(encAlu(6, 5, 2, `PPP_A, 2'b00, `FN_VSLL));
        emit(encAlu(7, 6, 5, `PPP_A, 2'b00, `FN_VSRL));
        emit(encImm(`OP_SW, 7, 21));
        emit(encImm(`OP_SW, 6, 22));
        emit(encImm(`OP_SW, 3, 23));
        runToHalt();
        r3 = laneRef(`FN_VADD, x, y, 2'b11);
        r4 = laneRef(`FN_VSUB, r3, x, 2'b10);
        r5 = laneRef(`FN_VADD, r4, r3, 2'b01);
        r6 = laneRef(`FN_VSLL, r5, y, 2'b00);
        r7 = laneRef(`FN_VSRL, r6, r5, 2'b00);
        compareWord("forward r5", r5, dmem[20]);
        compareWord("forward r7", r7, dmem[21]);
        compareWord("forward r6", r6, dmem[22]);
        compareWord("forward r3", r3, dmem[23]);
    endtask

    task automatic partitionTest();
        cpuPkg::ppp_t modes [5] = '{`PPP_A, `PPP_U, `PPP_D, `PPP_E, `PPP_O};
        cpuPkg::word_t oldW;
        cpuPkg::word_t newW;
        cpuPkg::word_t expW;
        beginTest();
        oldW = randWord();
        newW = randWord();
        dmemInit[0] = oldW;
        dmemInit[1] = newW;
        emit(encImm(`OP_LW, 2, 1));
        for (int k = 0; k < 5; k++) begin
            // Address 0x100 aliases word 0 and puts a partial mode in bits 10:8
            emit(encImm(`OP_LW, 3, 'h100));
            // Adding r0 passes newW through unchanged
            emit(encAlu(3, 2, 0, modes[k], 2'b11, `FN_VADD));
            // Stores read r3 from execute, from write-back and from the array
            emit(encImm(`OP_SW, 3, 24 + k));
            emit(encImm(`OP_SW, 3, 40 + k));
            emit(encImm(`OP_SW, 3, 48 + k));
        end
        runToHalt();
        for (int k = 0; k < 5; k++) begin
            expW = mergeRef(oldW, newW, modes[k]);
            compareWord($sformatf("partition ppp%0d", k), expW, dmem[24 + k]);
            compareWord($sformatf("partition wb ppp%0d", k), expW, dmem[40 + k]);
            compareWord($sformatf("partition reg ppp%0d", k), expW, dmem[48 + k]);
        end
    endtask

    task automatic branchTest();
        cpuPkg::word_t v;
        beginTest();
        v = randWord() | 64'd1;
        dmemInit[0] = v;
        emit(encImm(`OP_LW, 1, 0));
        emit(encImm(`OP_BEZ, 1, 40));
        emit(encImm(`OP_SW, 1, 32));
        emit(encImm(`OP_BNEZ, 1, 24));
        emit(encImm(`OP_SW, 1, 33));
        emit(encImm(`OP_SW, 1, 34));
        emit(encAlu(2, 1, 1, `PPP_A, 2'b11, `FN_VSUB));
        emit(encImm(`OP_BEZ, 2, 40));
        emit(encImm(`OP_SW, 1, 35));
        emit(encImm(`OP_SW, 1, 36));
        emit(encImm(`OP_BNEZ, 0, 52));
        emit(encImm(`OP_SW, 1, 37));
        runToHalt();
        checkFollows("bez not taken", 32'd8, 32'd12);
        checkFollows("bnez taken", 32'd16, 32'd24);
        checkFollows("bez taken", 32'd32, 32'd40);
        checkFollows("bnez not taken", 32'd44, 32'd48);
        compareWord("branch fall through", v, dmem[32]);
        compareWord("branch after not taken", v, dmem[37]);
        // Squashed and skipped stores leave the fill pattern
        for (int i = 33; i <= 36; i++) begin
            compareWord($sformatf("branch skipped %0d", i), fillWord(i), dmem[i]);
        end
    endtask

    initial begin
        reset = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {`OP_NOP, 26'd0};
            dmemInit[i] = fillWord(i);
        end
        resetTest();
        laneTest();
        forwardTest();
        partitionTest();
        branchTest();
        @(posedge clk);
        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, cpu_i.sva_i.failCount);
        if (valueErrors == 0 && otherErrors == 0 && cpu_i.sva_i.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verification/cpu_sva.sv */
// Bound assertions on the vector CPU top-level ports
`timescale 1ns/100ps

module cpu_sva (
    input logic          clk,
    input logic          reset,
    input cpuPkg::addr_t instrAddr,
    input logic          dmemEn,
    input logic          dmemWrEn
);

    // Read by the testbench summary
    int failCount = 0;

    // A store is always a memory access
    assert property (@(posedge clk) disable iff (reset) dmemWrEn |-> dmemEn)
        else begin
            failCount++;
            $error("dmemWrEn high without dmemEn");
        end

    assert property (@(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instrAddr not word aligned: %h", instrAddr);
        end

    // Pipeline holds NOPs once reset has been seen
    assert property (@(posedge clk) reset |=> (instrAddr == '0 && !dmemEn && !dmemWrEn))
        else begin
            failCount++;
            $error("Control outputs active in the cycle after reset");
        end

endmodule

bind cpu cpu_sva sva_i (
    .clk       (clk),
    .reset     (reset),
    .instrAddr (instrAddr),
    .dmemEn    (dmemEn),
    .dmemWrEn  (dmemWrEn)
);
